/* vlog.f */
+incdir+testbench
verilog/ex_pkg.sv
verilog/div_step_counter.sv
verilog/div_datapath.sv
verilog/hilo_reg.sv
verilog/ex_alu.sv
verilog/ex_ctrl.sv
verilog/ex_unit.sv
testbench/tb_ex_unit.sv

/* Bender.yml */
package:
  name: ex_unit

sources:
  - files:
      - verilog/ex_pkg.sv
      - verilog/div_step_counter.sv
      - verilog/div_datapath.sv
      - verilog/hilo_reg.sv
      - verilog/ex_alu.sv
      - verilog/ex_ctrl.sv
      - verilog/ex_unit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ex_unit.sv

/* testbench/tb_ex_tasks.svh */
// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
endfunction

task automatic check_val(input string name, input logic [DATA_W-1:0] exp_v,
                         input logic [DATA_W-1:0] act_v);
    assert (act_v === exp_v)
    else
    begin
        $display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
        $display("Some tests failed");
        $fatal(1, "stopping at the first mismatch");
    end
endtask

// four-phase handshake with all inputs driven on the falling edge
task automatic do_op(input ex_pkg::alu_op_e op, input logic [DATA_W-1:0] a,
                     input logic [DATA_W-1:0] b, input logic [ex_pkg::IMM_W-1:0] imm,
                     input logic [ex_pkg::SHAMT_W-1:0] sh, output logic [DATA_W-1:0] res,
                     output logic ovf, output logic wb);
    @(negedge clk);
    op_i     = op;
    rs_val_i = a;
    rt_val_i = b;
    imm_i    = imm;
    shamt_i  = sh;
    req_i    = 1'b1;
    @(negedge clk);
    while (!ack_o)
        @(negedge clk);
    res   = result_o;
    ovf   = overflow_o;
    wb    = wb_en_o;
    req_i = 1'b0;
    while (ack_o)
        @(negedge clk);
endtask

// expected outcome from the MIPS instruction definitions
task automatic model_single(input ex_pkg::alu_op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b, input logic [ex_pkg::IMM_W-1:0] imm,
                            input logic [ex_pkg::SHAMT_W-1:0] sh,
                            output logic [DATA_W-1:0] res, output logic ovf, output logic wb);
    logic [DATA_W:0]   wide;
    logic [DATA_W-1:0] se;
    logic [DATA_W-1:0] ze;
    int                n;
    se   = {{(DATA_W - ex_pkg::IMM_W){imm[ex_pkg::IMM_W-1]}}, imm};
    ze   = {{(DATA_W - ex_pkg::IMM_W){1'b0}}, imm};
    wide = '0;
    res  = '0;
    ovf  = 1'b0;
    wb   = 1'b1;
    n    = 0;
    case (op)
        ex_pkg::OP_ADD:   wide = {a[DATA_W-1], a} + {b[DATA_W-1], b};
        ex_pkg::OP_SUB:   wide = {a[DATA_W-1], a} - {b[DATA_W-1], b};
        ex_pkg::OP_ADDI:  wide = {a[DATA_W-1], a} + {se[DATA_W-1], se};
        ex_pkg::OP_ADDU:  res = a + b;
        ex_pkg::OP_SUBU:  res = a - b;
        ex_pkg::OP_ADDIU: res = a + se;
        ex_pkg::OP_AND:   res = a & b;
        ex_pkg::OP_ANDI:  res = a & ze;
        ex_pkg::OP_OR:    res = a | b;
        ex_pkg::OP_ORI:   res = a | ze;
        ex_pkg::OP_XOR:   res = a ^ b;
        ex_pkg::OP_XORI:  res = a ^ ze;
        ex_pkg::OP_NOR:   res = ~(a | b);
        ex_pkg::OP_LUI:   res = ze << (DATA_W - ex_pkg::IMM_W);
        ex_pkg::OP_SLL:   res = b << sh;
        ex_pkg::OP_SRL:   res = b >> sh;
        ex_pkg::OP_SRA:   res = $signed(b) >>> sh;
        ex_pkg::OP_SLLV:  res = b << a[ex_pkg::SHAMT_W-1:0];
        ex_pkg::OP_SRLV:  res = b >> a[ex_pkg::SHAMT_W-1:0];
        ex_pkg::OP_SRAV:  res = $signed(b) >>> a[ex_pkg::SHAMT_W-1:0];
        ex_pkg::OP_SLT:   res = ($signed(a) < $signed(b)) ? 1 : 0;
        ex_pkg::OP_SLTU:  res = (a < b) ? 1 : 0;
        ex_pkg::OP_SLTI:  res = ($signed(a) < $signed(se)) ? 1 : 0;
        ex_pkg::OP_SLTIU: res = (a < se) ? 1 : 0;
        ex_pkg::OP_CLZ:
        begin
            while (n < DATA_W && !a[DATA_W-1-n])
                n++;
            res = n;
        end
        ex_pkg::OP_CLO:
        begin
            while (n < DATA_W && a[DATA_W-1-n])
                n++;
            res = n;
        end
        ex_pkg::OP_MOVZ:
        begin
            res = a;
            wb  = (b == '0);
        end
        ex_pkg::OP_MOVN:
        begin
            res = a;
            wb  = (b != '0);
        end
        ex_pkg::OP_MFHI:  res = exp_hi;
        ex_pkg::OP_MFLO:  res = exp_lo;
        // multiply and divide write no register
        default:          wb = 1'b0;
    endcase
    if (op inside {ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_ADDI})
    begin
        res = wide[DATA_W-1:0];
        ovf = wide[DATA_W] != wide[DATA_W-1];
        wb  = !ovf;
    end
endtask

task automatic run_single(input string test, input ex_pkg::alu_op_e op,
                          input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                          input logic [ex_pkg::IMM_W-1:0] imm,
                          input logic [ex_pkg::SHAMT_W-1:0] sh);
    logic [DATA_W-1:0] res;
    logic [DATA_W-1:0] exp_res;
    logic              ovf;
    logic              wb;
    logic              exp_ovf;
    logic              exp_wb;
    string             label;
    label = $sformatf("%s %s", test, op.name());
    model_single(op, a, b, imm, sh, exp_res, exp_ovf, exp_wb);
    do_op(op, a, b, imm, sh, res, ovf, wb);
    // the result of a trapping add is not written back
    if (!exp_ovf)
        check_val({label, " result"}, exp_res, res);
    check_val({label, " overflow"}, exp_ovf, ovf);
    check_val({label, " wb_en"}, exp_wb, wb);
endtask

task automatic run_random(input string test, input ex_pkg::alu_op_e op);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] r;
    a = next_rand();
    b = next_rand();
    r = next_rand();
    run_single(test, op, a, b, r[ex_pkg::IMM_W-1:0], r[DATA_W-1 -: ex_pkg::SHAMT_W]);
endtask

task automatic mult_and_read(input ex_pkg::alu_op_e op, input logic [DATA_W-1:0] a,
                             input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] p;
    logic [DATA_W-1:0]   res;
    logic                ovf;
    logic                wb;
    if (op == ex_pkg::OP_MULT)
        p = {{DATA_W{a[DATA_W-1]}}, a} * {{DATA_W{b[DATA_W-1]}}, b};
    else
        p = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    do_op(op, a, b, '0, '0, res, ovf, wb);
    exp_hi = p[2*DATA_W-1:DATA_W];
    exp_lo = p[DATA_W-1:0];
    check_val("mult hi_o", exp_hi, hi_o);
    check_val("mult lo_o", exp_lo, lo_o);
    run_single("mult", ex_pkg::OP_MFHI, '0, '0, '0, '0);
    run_single("mult", ex_pkg::OP_MFLO, '0, '0, '0, '0);
endtask

// quotient rounds toward zero and the remainder follows the dividend's sign
task automatic div_and_read(input ex_pkg::alu_op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] res;
    logic              ovf;
    logic              wb;
    do_op(op, a, b, '0, '0, res, ovf, wb);
    if (op == ex_pkg::OP_DIV)
    begin
        exp_lo = $signed(a) / $signed(b);
        exp_hi = $signed(a) % $signed(b);
    end
    else
    begin
        exp_lo = a / b;
        exp_hi = a % b;
    end
    check_val("div hi_o", exp_hi, hi_o);
    check_val("div lo_o", exp_lo, lo_o);
    run_single("div", ex_pkg::OP_MFHI, '0, '0, '0, '0);
    run_single("div", ex_pkg::OP_MFLO, '0, '0, '0, '0);
endtask

/* testbench/tb_ex_unit.sv */
`timescale 1ns/1ps

module tb_ex_unit;

    localparam int DATA_W     = 32;
    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 8;
    // handshakes issued by all tests together
    localparam int N_OPS      = 3 + (19 + 6 * N_RAND) + (2 + 20 * N_RAND) + 68
                                + (3 + 6 * N_RAND) + 6 * N_RAND;
    localparam int TIMEOUT_NS = N_OPS * (DATA_W + 6) * CLK_PERIOD * 2;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       req_i;
    ex_pkg::alu_op_e            op_i;
    logic [DATA_W-1:0]          rs_val_i;
    logic [DATA_W-1:0]          rt_val_i;
    logic [ex_pkg::IMM_W-1:0]   imm_i;
    logic [ex_pkg::SHAMT_W-1:0] shamt_i;
    logic                       ack_o;
    logic [DATA_W-1:0]          result_o;
    logic                       overflow_o;
    logic                       wb_en_o;
    logic [DATA_W-1:0]          hi_o;
    logic [DATA_W-1:0]          lo_o;

    logic [31:0]                seed;
    // HI/LO contents expected after the last multiply or divide
    logic [DATA_W-1:0]          exp_hi;
    logic [DATA_W-1:0]          exp_lo;

    `include "tb_ex_tasks.svh"

    ex_unit #(.DATA_W(DATA_W)) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .op_i       (op_i),
        .rs_val_i   (rs_val_i),
        .rt_val_i   (rt_val_i),
        .imm_i      (imm_i),
        .shamt_i    (shamt_i),
        .ack_o      (ack_o),
        .result_o   (result_o),
        .overflow_o (overflow_o),
        .wb_en_o    (wb_en_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic test_reset_handshake();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] exp_res;
        logic              exp_ovf;
        logic              exp_wb;
        check_val("reset ack", 1'b0, ack_o);
        run_single("reset", ex_pkg::OP_MFHI, '0, '0, '0, '0);
        run_single("reset", ex_pkg::OP_MFLO, '0, '0, '0, '0);
        a = next_rand();
        b = next_rand();
        model_single(ex_pkg::OP_OR, a, b, '0, '0, exp_res, exp_ovf, exp_wb);
        @(negedge clk);
        op_i     = ex_pkg::OP_OR;
        rs_val_i = a;
        rt_val_i = b;
        req_i    = 1'b1;
        @(negedge clk);
        check_val("handshake ack before latency", 1'b0, ack_o);
        @(negedge clk);
        check_val("handshake ack after one cycle", 1'b1, ack_o);
        check_val("handshake result", exp_res, result_o);
        // requester keeps req high, ack and result must hold
        repeat (4)
        begin
            @(negedge clk);
            check_val("handshake ack held", 1'b1, ack_o);
            check_val("handshake result held", exp_res, result_o);
        end
        req_i = 1'b0;
        @(negedge clk);
        check_val("handshake ack after release", 1'b1, ack_o);
        @(negedge clk);
        check_val("handshake ack dropped", 1'b0, ack_o);
    endtask

    task automatic test_add_sub();
        for (int k = ex_pkg::OP_ADD; k <= ex_pkg::OP_SUBU; k++)
        begin
            run_single("add_sub", ex_pkg::alu_op_e'(k), 32'h7fffffff, 32'h00000001, '0, '0);
            run_single("add_sub", ex_pkg::alu_op_e'(k), 32'h80000000, 32'hffffffff, '0, '0);
            run_single("add_sub", ex_pkg::alu_op_e'(k), 32'h80000000, 32'h00000001, '0, '0);
            run_single("add_sub", ex_pkg::alu_op_e'(k), 32'h7fffffff, 32'hffffffff, '0, '0);
        end
        run_single("add_sub", ex_pkg::OP_ADDI, 32'h7fffffff, '0, 16'h0001, '0);
        run_single("add_sub", ex_pkg::OP_ADDI, 32'h80000000, '0, 16'h8000, '0);
        run_single("add_sub", ex_pkg::OP_ADDIU, 32'h7fffffff, '0, 16'h0001, '0);
        repeat (N_RAND)
        begin
            for (int k = ex_pkg::OP_ADD; k <= ex_pkg::OP_ADDIU; k++)
                run_random("add_sub", ex_pkg::alu_op_e'(k));
        end
    endtask

    task automatic test_logic();
        repeat (N_RAND)
        begin
            for (int k = ex_pkg::OP_AND; k <= ex_pkg::OP_SLTIU; k++)
                run_random("logic", ex_pkg::alu_op_e'(k));
            run_random("logic", ex_pkg::OP_MOVZ);
            run_random("logic", ex_pkg::OP_MOVN);
        end
        // random rt is almost never zero
        run_single("logic", ex_pkg::OP_MOVZ, next_rand(), '0, '0, '0);
        run_single("logic", ex_pkg::OP_MOVN, next_rand(), '0, '0, '0);
    endtask

    task automatic test_count();
        logic [DATA_W-1:0] bit_w;
        run_single("count", ex_pkg::OP_CLZ, '0, '0, '0, '0);
        run_single("count", ex_pkg::OP_CLZ, '1, '0, '0, '0);
        run_single("count", ex_pkg::OP_CLO, '0, '0, '0, '0);
        run_single("count", ex_pkg::OP_CLO, '1, '0, '0, '0);
        for (int i = 0; i < DATA_W; i++)
        begin
            bit_w = '0;
            bit_w[i] = 1'b1;
            run_single("count", ex_pkg::OP_CLZ, bit_w, '0, '0, '0);
            run_single("count", ex_pkg::OP_CLO, ~bit_w, '0, '0, '0);
        end
    endtask

    task automatic test_mult();
        mult_and_read(ex_pkg::OP_MULT, 32'h80000000, 32'h80000000);
        repeat (N_RAND)
        begin
            mult_and_read(ex_pkg::OP_MULT, next_rand(), next_rand());
            mult_and_read(ex_pkg::OP_MULTU, next_rand(), next_rand());
        end
    endtask

    task automatic test_div();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        repeat (N_RAND)
        begin
            a = next_rand();
            b = next_rand();
            // shrink the divisor so quotients get more than a bit or two
            b = $signed(b) >>> (next_rand() % 24);
            if (b == '0)
                b = 1;
            if (a == 32'h80000000 && b == 32'hffffffff)
                b = 3;
            div_and_read(ex_pkg::OP_DIV, a, b);
            div_and_read(ex_pkg::OP_DIVU, a, b);
        end
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the tests in time");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        rst_n    = 1'b0;
        req_i    = 1'b0;
        op_i     = ex_pkg::OP_ADD;
        rs_val_i = '0;
        rt_val_i = '0;
        imm_i    = '0;
        shamt_i  = '0;
        seed     = 32'd53713;
        exp_hi   = '0;
        exp_lo   = '0;
        repeat (3)
            @(negedge clk);
        rst_n = 1'b1;
        test_reset_handshake();
        test_add_sub();
        test_logic();
        test_count();
        test_mult();
        test_div();
        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog/ex_unit.sv */
`timescale 1ns/1ps

module ex_unit #(
    parameter int DATA_W = ex_pkg::DATA_W_DEF
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_i,
    input  ex_pkg::alu_op_e             op_i,
    input  logic [DATA_W-1:0]           rs_val_i,
    input  logic [DATA_W-1:0]           rt_val_i,
    input  logic [ex_pkg::IMM_W-1:0]    imm_i,
    input  logic [ex_pkg::SHAMT_W-1:0]  shamt_i,
    output logic                        ack_o,
    output logic [DATA_W-1:0]           result_o,
    output logic                        overflow_o,
    output logic                        wb_en_o,
    output logic [DATA_W-1:0]           hi_o,
    output logic [DATA_W-1:0]           lo_o
);

    logic                res_capture;
    logic                div_load;
    logic                div_step;
    logic                cnt_start;
    logic                cnt_en;
    logic                cnt_last;
    logic                hilo_we;
    logic                hilo_src;
    logic [2*DATA_W-1:0] product;
    logic [DATA_W-1:0]   quotient;
    logic [DATA_W-1:0]   remainder;

    ex_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (req_i),
        .op_i          (op_i),
        .cnt_last_i    (cnt_last),
        .ack_o         (ack_o),
        .res_capture_o (res_capture),
        .div_load_o    (div_load),
        .div_step_o    (div_step),
        .cnt_start_o   (cnt_start),
        .cnt_en_o      (cnt_en),
        .hilo_we_o     (hilo_we),
        .hilo_src_o    (hilo_src)
    );

    ex_alu #(.DATA_W(DATA_W)) u_alu (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_capture_i (res_capture),
        .op_i          (op_i),
        .rs_val_i      (rs_val_i),
        .rt_val_i      (rt_val_i),
        .imm_i         (imm_i),
        .shamt_i       (shamt_i),
        .hi_i          (hi_o),
        .lo_i          (lo_o),
        .result_o      (result_o),
        .overflow_o    (overflow_o),
        .wb_en_o       (wb_en_o),
        .product_o     (product)
    );

    div_datapath #(.DATA_W(DATA_W)) u_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .div_load_i  (div_load),
        .div_step_i  (div_step),
        .op_i        (op_i),
        .dividend_i  (rs_val_i),
        .divisor_i   (rt_val_i),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    // one iteration per quotient bit
    div_step_counter #(.STEPS(DATA_W)) u_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .cnt_start_i (cnt_start),
        .cnt_en_i    (cnt_en),
        .cnt_last_o  (cnt_last)
    );

    hilo_reg #(.DATA_W(DATA_W)) u_hilo (
        .clk         (clk),
        .rst_n       (rst_n),
        .hilo_we_i   (hilo_we),
        .hilo_src_i  (hilo_src),
        .product_i   (product),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

endmodule

/* verilog/ex_ctrl.sv */
`timescale 1ns/1ps

module ex_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_i,
    input  ex_pkg::alu_op_e op_i,
    input  logic            cnt_last_i,
    output logic            ack_o,
    output logic            res_capture_o,
    output logic            div_load_o,
    output logic            div_step_o,
    output logic            cnt_start_o,
    output logic            cnt_en_o,
    output logic            hilo_we_o,
    output logic            hilo_src_o
);

    typedef enum logic [2:0] {
        IDLE,
        DIVIDE,
        FIXUP,
        DONE,
        WAIT_REQ_LOW
    } state_e;

    state_e            state_q;
    state_e            state_d;
    ex_pkg::op_class_e cls;
    logic              start;

    assign cls = ex_pkg::op_class(op_i);

    // a new request only once the previous ack has dropped
    assign start = (state_q == IDLE) && req_i && !ack_o;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (start)
                    state_d = (cls == ex_pkg::DIV_OP) ? DIVIDE : DONE;
            end
            DIVIDE:
            begin
                if (cnt_last_i)
                    state_d = FIXUP;
            end
            FIXUP:        state_d = DONE;
            DONE:         state_d = WAIT_REQ_LOW;
            WAIT_REQ_LOW:
            begin
                if (!req_i)
                    state_d = IDLE;
            end
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            ack_o   <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // ack rises leaving DONE and falls one cycle after IDLE is reached
            ack_o   <= (state_q == DONE) || (state_q == WAIT_REQ_LOW);
        end
    end

    assign div_load_o    = start && (cls == ex_pkg::DIV_OP);
    assign cnt_start_o   = start && (cls == ex_pkg::DIV_OP);
    assign div_step_o    = (state_q == DIVIDE);
    assign cnt_en_o      = (state_q == DIVIDE);
    assign res_capture_o = (state_q == DONE);
    assign hilo_we_o     = (state_q == DONE) && (cls != ex_pkg::SINGLE);
    // 1 selects the divider
    assign hilo_src_o    = (cls == ex_pkg::DIV_OP);

endmodule

/* verilog/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu #(
    parameter int DATA_W = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        res_capture_i,
    input  ex_pkg::alu_op_e             op_i,
    input  logic [DATA_W-1:0]           rs_val_i,
    input  logic [DATA_W-1:0]           rt_val_i,
    input  logic [ex_pkg::IMM_W-1:0]    imm_i,
    input  logic [ex_pkg::SHAMT_W-1:0]  shamt_i,
    input  logic [DATA_W-1:0]           hi_i,
    input  logic [DATA_W-1:0]           lo_i,
    output logic [DATA_W-1:0]           result_o,
    output logic                        overflow_o,
    output logic                        wb_en_o,
    output logic [2*DATA_W-1:0]         product_o
);

    localparam int EXT_W = DATA_W - ex_pkg::IMM_W;

    logic [DATA_W-1:0]          imm_sext;
    logic [DATA_W-1:0]          imm_zext;
    logic [DATA_W-1:0]          op_b;
    logic [DATA_W-1:0]          b_eff;
    logic [DATA_W-1:0]          sum;
    logic [DATA_W-1:0]          res_d;
    logic                       use_imm;
    logic                       sub_op;
    logic                       add_ovf;
    logic                       lt_s;
    logic                       lt_u;
    logic                       ovf_d;
    logic                       wb_d;
    logic                       mul_sign;
    logic [ex_pkg::SHAMT_W-1:0] sa;
    logic signed [DATA_W:0]     mul_a;
    logic signed [DATA_W:0]     mul_b;
    logic signed [2*DATA_W+1:0] mul_full;

    // leading zero count, scanning up so the highest set bit wins
    function automatic logic [DATA_W-1:0] lead_zeros(input logic [DATA_W-1:0] v);
        logic [DATA_W-1:0] n;
        n = DATA_W'(DATA_W);
        for (int i = 0; i < DATA_W; i++)
        begin
            if (v[i])
                n = DATA_W'(DATA_W - 1 - i);
        end
        return n;
    endfunction

    assign imm_sext = {{EXT_W{imm_i[ex_pkg::IMM_W-1]}}, imm_i};
    assign imm_zext = {{EXT_W{1'b0}}, imm_i};

    assign use_imm = op_i inside {ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU,
                                  ex_pkg::OP_SLTI, ex_pkg::OP_SLTIU};
    assign sub_op  = op_i inside {ex_pkg::OP_SUB, ex_pkg::OP_SUBU,
                                  ex_pkg::OP_SLT, ex_pkg::OP_SLTI};

    // shared adder, subtract as a + ~b + 1
    assign op_b    = use_imm ? imm_sext : rt_val_i;
    assign b_eff   = sub_op ? ~op_b : op_b;
    assign sum     = rs_val_i + b_eff + {{(DATA_W-1){1'b0}}, sub_op};
    assign add_ovf = (rs_val_i[DATA_W-1] == b_eff[DATA_W-1]) &&
                     (sum[DATA_W-1] != rs_val_i[DATA_W-1]);
    assign lt_s    = sum[DATA_W-1] ^ add_ovf;
    assign lt_u    = rs_val_i < op_b;

    // variable shifts take the amount from rs
    assign sa = (op_i inside {ex_pkg::OP_SLLV, ex_pkg::OP_SRLV, ex_pkg::OP_SRAV}) ?
                rs_val_i[ex_pkg::SHAMT_W-1:0] : shamt_i;

    // one extra bit lets a single signed multiplier cover MULTU too
    assign mul_sign  = ex_pkg::is_signed_op(op_i);
    assign mul_a     = {mul_sign & rs_val_i[DATA_W-1], rs_val_i};
    assign mul_b     = {mul_sign & rt_val_i[DATA_W-1], rt_val_i};
    assign mul_full  = mul_a * mul_b;
    assign product_o = mul_full[2*DATA_W-1:0];

    always_comb
    begin
        res_d = '0;
        ovf_d = 1'b0;
        wb_d  = 1'b1;
        case (op_i)
            ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_ADDI:
            begin
                res_d = sum;
                ovf_d = add_ovf;
                // trap on overflow, nothing is written back
                wb_d  = !add_ovf;
            end
            ex_pkg::OP_ADDU, ex_pkg::OP_SUBU, ex_pkg::OP_ADDIU: res_d = sum;
            ex_pkg::OP_AND:   res_d = rs_val_i & rt_val_i;
            ex_pkg::OP_ANDI:  res_d = rs_val_i & imm_zext;
            ex_pkg::OP_OR:    res_d = rs_val_i | rt_val_i;
            ex_pkg::OP_ORI:   res_d = rs_val_i | imm_zext;
            ex_pkg::OP_XOR:   res_d = rs_val_i ^ rt_val_i;
            ex_pkg::OP_XORI:  res_d = rs_val_i ^ imm_zext;
            ex_pkg::OP_NOR:   res_d = ~(rs_val_i | rt_val_i);
            ex_pkg::OP_LUI:   res_d = {imm_i, {EXT_W{1'b0}}};
            ex_pkg::OP_SLL, ex_pkg::OP_SLLV: res_d = rt_val_i << sa;
            ex_pkg::OP_SRL, ex_pkg::OP_SRLV: res_d = rt_val_i >> sa;
            ex_pkg::OP_SRA, ex_pkg::OP_SRAV: res_d = $signed(rt_val_i) >>> sa;
            ex_pkg::OP_SLT, ex_pkg::OP_SLTI:   res_d = {{(DATA_W-1){1'b0}}, lt_s};
            ex_pkg::OP_SLTU, ex_pkg::OP_SLTIU: res_d = {{(DATA_W-1){1'b0}}, lt_u};
            ex_pkg::OP_CLZ:   res_d = lead_zeros(rs_val_i);
            ex_pkg::OP_CLO:   res_d = lead_zeros(~rs_val_i);
            ex_pkg::OP_MOVZ:
            begin
                res_d = rs_val_i;
                wb_d  = (rt_val_i == '0);
            end
            ex_pkg::OP_MOVN:
            begin
                res_d = rs_val_i;
                wb_d  = (rt_val_i != '0);
            end
            ex_pkg::OP_MFHI:  res_d = hi_i;
            ex_pkg::OP_MFLO:  res_d = lo_i;
            // multiply and divide only update HI/LO
            default:          wb_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            result_o   <= '0;
            overflow_o <= 1'b0;
            wb_en_o    <= 1'b0;
        end
        else if (res_capture_i)
        begin
            result_o   <= res_d;
            overflow_o <= ovf_d;
            wb_en_o    <= wb_d;
        end
    end

endmodule

/* verilog/hilo_reg.sv */
`timescale 1ns/1ps

module hilo_reg #(
    parameter int DATA_W = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hilo_we_i,
    input  logic                hilo_src_i,
    input  logic [2*DATA_W-1:0] product_i,
    input  logic [DATA_W-1:0]   quotient_i,
    input  logic [DATA_W-1:0]   remainder_i,
    output logic [DATA_W-1:0]   hi_o,
    output logic [DATA_W-1:0]   lo_o
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hi_o <= '0;
            lo_o <= '0;
        end
        else if (hilo_we_i)
        begin
            if (hilo_src_i)
            begin
                // remainder in HI, quotient in LO
                hi_o <= remainder_i;
                lo_o <= quotient_i;
            end
            else
            begin
                hi_o <= product_i[2*DATA_W-1:DATA_W];
                lo_o <= product_i[DATA_W-1:0];
            end
        end
    end

endmodule

/* verilog/div_datapath.sv */
`timescale 1ns/1ps

module div_datapath #(
    parameter int DATA_W = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                div_load_i,
    input  logic                div_step_i,
    input  ex_pkg::alu_op_e     op_i,
    input  logic [DATA_W-1:0]   dividend_i,
    input  logic [DATA_W-1:0]   divisor_i,
    output logic [DATA_W-1:0]   quotient_o,
    output logic [DATA_W-1:0]   remainder_o
);

    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] quo_q;
    logic [DATA_W-1:0] dvs_q;
    logic              neg_quo_q;
    logic              neg_rem_q;
    logic              step_d;
    logic              signed_op;
    logic              a_neg;
    logic              b_neg;
    logic [DATA_W-1:0] a_mag;
    logic [DATA_W-1:0] b_mag;
    logic [DATA_W:0]   shifted;
    logic [DATA_W:0]   trial;

    // signed divide works on magnitudes, signs are applied at the end
    assign signed_op = ex_pkg::is_signed_op(op_i);
    assign a_neg     = signed_op & dividend_i[DATA_W-1];
    assign b_neg     = signed_op & divisor_i[DATA_W-1];
    assign a_mag     = a_neg ? -dividend_i : dividend_i;
    assign b_mag     = b_neg ? -divisor_i : divisor_i;

    // bring in the next dividend bit and try the subtraction
    assign shifted = {rem_q, quo_q[DATA_W-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk)
    begin
        if (div_load_i)
        begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            dvs_q     <= b_mag;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
        end
        else if (div_step_i)
        begin
            // restore when the trial went negative
            rem_q <= trial[DATA_W] ? shifted[DATA_W-1:0] : trial[DATA_W-1:0];
            quo_q <= {quo_q[DATA_W-2:0], !trial[DATA_W]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            step_d <= 1'b0;
        else
            step_d <= div_step_i;
    end

    // sign fix-up one cycle behind each step
    always_ff @(posedge clk)
    begin
        if (step_d)
        begin
            quotient_o  <= neg_quo_q ? -quo_q : quo_q;
            remainder_o <= neg_rem_q ? -rem_q : rem_q;
        end
    end

endmodule

/* verilog/div_step_counter.sv */
`timescale 1ns/1ps

module div_step_counter #(
    parameter int STEPS = 32
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cnt_start_i,
    input  logic cnt_en_i,
    output logic cnt_last_o
);

    localparam int CNT_W = $clog2(STEPS + 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cnt_q <= '0;
        else if (cnt_start_i)
            cnt_q <= CNT_W'(STEPS);
        else if (cnt_en_i && (cnt_q != '0))
            cnt_q <= cnt_q - 1'b1;
    end

    // one step left
    assign cnt_last_o = (cnt_q == CNT_W'(1));

endmodule

/* verilog/ex_pkg.sv */
package ex_pkg;

    // datapath width used when the top level is not overridden
    parameter int DATA_W_DEF = 32;
    parameter int IMM_W      = 16;
    parameter int SHAMT_W    = 5;

    // one code per supported instruction
    typedef enum logic [5:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_ADDI, OP_ADDIU,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR, OP_LUI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
        OP_CLZ, OP_CLO,
        OP_MOVZ, OP_MOVN,
        OP_MULT, OP_MULTU,
        OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO
    } alu_op_e;

    // how the control FSM sequences an operation
    typedef enum logic [1:0] {
        SINGLE,
        MULT_OP,
        DIV_OP
    } op_class_e;

    function automatic op_class_e op_class(input alu_op_e op);
        case (op)
            OP_MULT, OP_MULTU: return MULT_OP;
            OP_DIV, OP_DIVU:   return DIV_OP;
            default:           return SINGLE;
        endcase
    endfunction

    // signed variants of the HI/LO producing operations
    function automatic logic is_signed_op(input alu_op_e op);
        return (op == OP_DIV) || (op == OP_MULT);
    endfunction

endpackage
